/* Bender.yml */
package:
  name: mips_ex

sources:
  - hdl/mips_ex_pkg.sv
  - hdl/sglalu.sv
  - hdl/muldiv_unit.sv
  - hdl/execute_stage.sv
  - target: test
    files:
      - bench/execute_stage_tb.sv

/* bench/execute_input.txt */
# oper func source_a source_b cp0_rt_data exp_result exp_ov check, all in hex
# check 0 marks MTHI/MTLO and multiply/divide lines whose result is not compared
1 01 f0f0ff00 0ff0f0f0 00000000 00f0f000 0 1
1 02 f0f0ff00 0ff0f0f0 00000000 fff0fff0 0 1
1 03 f0f0ff00 0ff0f0f0 00000000 ff000ff0 0 1
1 04 f0f0ff00 0ff0f0f0 00000000 000f000f 0 1
1 05 00000000 00001234 00000000 12340000 0 1
1 06 80000001 00000004 00000000 00000010 0 1
1 07 80000000 00000004 00000000 08000000 0 1
1 08 80000000 00000004 00000000 f8000000 0 1
1 08 87654321 00000000 00000000 87654321 0 1
1 08 87654321 0000001f 00000000 ffffffff 0 1
1 08 87654321 00000024 00000000 f8765432 0 1
1 09 7fffffff 00000001 00000000 80000000 1 1
2 09 7fffffff 00000001 00000000 80000000 0 1
1 0a 80000000 00000001 00000000 7fffffff 1 1
2 0a 80000000 00000001 00000000 7fffffff 0 1
1 0a 00000003 00000005 00000000 fffffffe 0 1
1 0b ffffffff 00000001 00000000 00000001 0 1
2 0b ffffffff 00000001 00000000 00000000 0 1
5 00 cafef00d 00000000 00000000 00000000 0 0
6 00 12345678 00000000 00000000 00000000 0 0
3 01 00000000 00000000 00000000 cafef00d 0 1
4 01 00000000 00000000 00000000 12345678 0 1
7 01 00000000 0000000c deadbeef deadbeef 0 1
1 0c fffffffd 00000007 00000000 00000000 0 0
3 01 00000000 00000000 00000000 ffffffff 0 1
4 01 00000000 00000000 00000000 ffffffeb 0 1
2 0c ffffffff 00000002 00000000 00000000 0 0
1 09 00000010 00000020 00000000 00000030 0 1
3 01 00000000 00000000 00000000 00000001 0 1
4 01 00000000 00000000 00000000 fffffffe 0 1
1 0d ffffffe5 00000004 00000000 00000000 0 0
4 01 00000000 00000000 00000000 fffffffa 0 1
3 01 00000000 00000000 00000000 fffffffd 0 1
2 0d 00000064 00000007 00000000 00000000 0 0
4 01 00000000 00000000 00000000 0000000e 0 1
3 01 00000000 00000000 00000000 00000002 0 1
2 0d 00001234 00000000 00000000 00000000 0 0
4 01 00000000 00000000 00000000 ffffffff 0 1
3 01 00000000 00000000 00000000 00001234 0 1

/* bench/execute_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb
    import mips_ex_pkg::*;
();

    localparam int STEP_BITS    = 2;
    localparam int STEPS        = DATA_W / STEP_BITS;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_VECTORS  = 64;
    localparam int STALL_LIMIT  = STEPS + 2;
    localparam int VALID_WAIT   = 2;

    // one line of the data file
    typedef struct packed {
        ex_req_t req;
        data_t   exp_result;
        logic    exp_ov;
        logic    check;
    } vector_t;

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    ex_req_t in_req;
    logic    stall;
    logic    out_valid;
    wb_t     out_wb;
    logic    busy;

    vector_t vectors [MAX_VECTORS];
    int      vec_count;
    int      errors;
    int      checks;
    logic    loaded;

    execute_stage #(
        .STEP_BITS (STEP_BITS)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .stall     (stall),
        .out_valid (out_valid),
        .out_wb    (out_wb),
        .busy      (busy)
    );

    always
    begin
        #(CLK_PERIOD / 2);
        clk = ~clk;
    end

    // comment lines start with a hash and every other line holds eight hex fields
    task automatic load_vectors();
        int         fd;
        int         fields;
        string      line;
        logic [3:0] oper;
        logic [4:0] func;
        data_t      a;
        data_t      b;
        data_t      cp0;
        data_t      res;
        logic       ov;
        logic       check;
        fd = $fopen("bench/execute_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/execute_input.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && (vec_count < MAX_VECTORS))
            begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 0) && (line.getc(0) != "#"))
                begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                     oper, func, a, b, cp0, res, ov, check);
                    if (fields == 8)
                    begin
                        vectors[vec_count].req.oper        = oper_t'(oper);
                        vectors[vec_count].req.func        = func_t'(func);
                        vectors[vec_count].req.source_a    = a;
                        vectors[vec_count].req.source_b    = b;
                        vectors[vec_count].req.cp0_rt_data = cp0;
                        vectors[vec_count].exp_result      = res;
                        vectors[vec_count].exp_ov          = ov;
                        vectors[vec_count].check           = check;
                        vec_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // holds the request while stall is seen and returns on the falling edge after acceptance
    // stall is sampled a quarter period after the falling edge where it has settled
    task automatic issue(input vector_t v, input int index);
        int   stall_cycles;
        logic held;
        logic plain_alu;
        // only HI/LO readers, writers and multiply/divide may be held back
        plain_alu = ((v.req.oper == OPER_ALUS) || (v.req.oper == OPER_ALUU) ||
                     (v.req.oper == OPER_MFC0)) &&
                    (v.req.func != FUNC_MUL) && (v.req.func != FUNC_DIV);
        stall_cycles = 0;
        in_valid     = 1'b1;
        in_req       = v.req;
        #(CLK_PERIOD / 4);
        held = stall;
        while (held && (stall_cycles <= STALL_LIMIT))
        begin
            stall_cycles++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
            held = stall;
        end
        assert (stall_cycles <= STALL_LIMIT)
        else
        begin
            $display("vector %0d stayed stalled for more than %0d cycles", index, STALL_LIMIT);
            errors++;
        end
        assert (!plain_alu || (stall_cycles == 0))
        else
        begin
            $display("vector %0d is a plain ALU instruction but was stalled", index);
            errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // an accepted multiply or divide raises busy on the next edge and gives no writeback pulse
    task automatic check_md_start(input int index);
        checks++;
        assert (busy === 1'b1)
        else
        begin
            $display("FAIL busy vector %0d got %h expected %h", index, busy, 1'b1);
            errors++;
        end
        assert (out_valid === 1'b0)
        else
        begin
            $display("FAIL out_valid vector %0d got %h expected %h", index, out_valid, 1'b0);
            errors++;
        end
    endtask

    // out_valid is due on this falling edge and a short grace period is allowed
    task automatic check_result(input vector_t v, input int index);
        int waited;
        waited = 0;
        while (!out_valid && (waited < VALID_WAIT))
        begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (out_valid)
        else
        begin
            $display("vector %0d gave no out_valid within %0d cycles", index, VALID_WAIT);
            errors++;
        end
        if (out_valid)
        begin
            assert (out_wb.result === v.exp_result)
            else
            begin
                $display("FAIL out_wb.result vector %0d got %h expected %h",
                         index, out_wb.result, v.exp_result);
                errors++;
            end
            assert (out_wb.ov === v.exp_ov)
            else
            begin
                $display("FAIL out_wb.ov vector %0d got %h expected %h",
                         index, out_wb.ov, v.exp_ov);
                errors++;
            end
            // CP0 write data is always the rt operand
            assert (out_wb.cp0_data === v.req.source_b)
            else
            begin
                $display("FAIL out_wb.cp0_data vector %0d got %h expected %h",
                         index, out_wb.cp0_data, v.req.source_b);
                errors++;
            end
        end
    endtask

    // each vector gets the worst case of gap, stall and result wait with some margin
    initial
    begin
        wait (loaded && (vec_count > 0));
        #((vec_count * (STEPS + 8) + RESET_CYCLES + STEPS + 4) * CLK_PERIOD);
        $display("watchdog expired before all vectors were run");
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        int gap;
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        errors    = 0;
        checks    = 0;
        vec_count = 0;
        loaded    = 1'b0;
        void'($urandom(31317));
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && !busy && !stall && (out_wb == '0) && (uut.hilo == '0))
        else
        begin
            $display("outputs or HI/LO not cleared by reset");
            errors++;
        end
        assert (vec_count > 0)
        else
        begin
            $display("no vectors were read from the data file");
            errors++;
        end
        for (int i = 0; i < vec_count; i++)
        begin
            // random idle gap of zero to three cycles
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            issue(vectors[i], i);
            if ((vectors[i].req.func == FUNC_MUL) || (vectors[i].req.func == FUNC_DIV))
            begin
                check_md_start(i);
            end
            if (vectors[i].check)
            begin
                check_result(vectors[i], i);
            end
        end
        repeat (STEPS + 2) @(negedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/mips_ex_pkg.sv
hdl/sglalu.sv
hdl/muldiv_unit.sv
hdl/execute_stage.sv
bench/execute_stage_tb.sv

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import mips_ex_pkg::*;
#(
    parameter int STEP_BITS = 1
)
(
    input  wire          clk,
    input  wire          arst_n,
    input  wire          in_valid,
    input  wire ex_req_t in_req,
    output logic         stall,
    output logic         out_valid,
    output wb_t          out_wb,
    output logic         busy
);

    // outputs of the single-cycle ALU
    data_t   alu_result;
    logic    alu_ov;
    data_t   alu_cp0;
    md_req_t md_req;
    logic    alu_hi_write;
    logic    alu_lo_write;
    data_t   hilo_write_data;

    // current HI/LO contents from the multiply/divide unit
    hilo_t   hilo;

    logic    is_md_op;
    logic    uses_hilo;
    logic    accept;

    sglalu alu (
        .req             (in_req),
        .hilo            (hilo),
        .result          (alu_result),
        .ov              (alu_ov),
        .cp0_rd_data     (alu_cp0),
        .md_req          (md_req),
        .hi_write        (alu_hi_write),
        .lo_write        (alu_lo_write),
        .hilo_write_data (hilo_write_data)
    );

    // a multiply or divide is the only request the ALU forwards with a function
    assign is_md_op = (md_req.func != FUNC_NONE);

    // anything that reads or writes HI/LO has to wait for the unit to finish
    assign uses_hilo = is_md_op ||
                       (in_req.oper == OPER_MFHI) ||
                       (in_req.oper == OPER_MFLO) ||
                       (in_req.oper == OPER_MTHI) ||
                       (in_req.oper == OPER_MTLO);

    // plain ALU work keeps flowing while the unit is busy
    assign stall  = in_valid && busy && uses_hilo;
    assign accept = in_valid && !stall;

    muldiv_unit #(
        .STEP_BITS (STEP_BITS)
    ) muldiv (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (accept && is_md_op),
        .md_req          (md_req),
        .source_a        (in_req.source_a),
        .source_b        (in_req.source_b),
        .hi_write        (accept && alu_hi_write),
        .lo_write        (accept && alu_lo_write),
        .hilo_write_data (hilo_write_data),
        .busy            (busy),
        .hilo            (hilo)
    );

    // single-cycle results are registered for writeback
    // an accepted multiply or divide only starts the unit and gives no pulse
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
            out_wb    <= '0;
        end
        else
        begin
            out_valid <= accept && !is_md_op;
            if (accept && !is_md_op)
            begin
                out_wb.result   <= alu_result;
                out_wb.ov       <= alu_ov;
                out_wb.cp0_data <= alu_cp0;
            end
        end
    end

    // the source must keep a stalled request steady until it is taken
    a_hold_when_stalled : assert property (
        @(posedge clk) disable iff (!arst_n)
        (in_valid && stall) |=> (in_valid && $stable(in_req))
    ) else $error("execute_stage: request changed while stalled");

endmodule

`default_nettype wire

/* hdl/mips_ex_pkg.sv */
`default_nettype none

package mips_ex_pkg;

    // width of every datapath word handled by the execute stage
    localparam int DATA_W = 32;

    // one register-sized data word
    typedef logic [DATA_W-1:0] data_t;

    // operation class of an instruction as delivered by decode
    // the class picks signed or unsigned behaviour and the HI/LO/CP0 moves
    typedef enum logic [3:0] {
        OPER_ALUS = 4'h1,
        OPER_ALUU = 4'h2,
        OPER_MFHI = 4'h3,
        OPER_MFLO = 4'h4,
        OPER_MTHI = 4'h5,
        OPER_MTLO = 4'h6,
        OPER_MFC0 = 4'h7,
        OPER_NOP  = 4'h0
    } oper_t;

    // ALU function selected inside the operation class
    // FUNC_AND is also the move function for MFHI, MFLO and MFC0
    // FUNC_NONE must stay at zero since the multiply/divide request tests against it
    typedef enum logic [4:0] {
        FUNC_NONE = 5'd0,
        FUNC_AND  = 5'd1,
        FUNC_OR   = 5'd2,
        FUNC_XOR  = 5'd3,
        FUNC_NOR  = 5'd4,
        FUNC_LUI  = 5'd5,
        FUNC_SLL  = 5'd6,
        FUNC_SRL  = 5'd7,
        FUNC_SRA  = 5'd8,
        FUNC_ADD  = 5'd9,
        FUNC_SUB  = 5'd10,
        FUNC_SLT  = 5'd11,
        FUNC_MUL  = 5'd12,
        FUNC_DIV  = 5'd13
    } func_t;

    // one instruction as it enters the execute stage
    typedef struct packed {
        oper_t oper;
        func_t func;
        data_t source_a;
        data_t source_b;
        data_t cp0_rt_data;
    } ex_req_t;

    // multiply/divide command from the ALU decode
    // the operands reach the multiply/divide unit on their own ports
    typedef struct packed {
        func_t func;
        logic  sign;
    } md_req_t;

    // the architectural HI and LO registers
    typedef struct packed {
        data_t hi;
        data_t lo;
    } hilo_t;

    // single-cycle result handed on to writeback
    typedef struct packed {
        data_t result;
        logic  ov;
        data_t cp0_data;
    } wb_t;

endpackage

`default_nettype wire

/* hdl/muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
    import mips_ex_pkg::*;
#(
    parameter int STEP_BITS = 1
)
(
    input  wire          clk,
    input  wire          arst_n,
    input  wire          start,
    input  wire md_req_t md_req,
    input  wire data_t   source_a,
    input  wire data_t   source_b,
    input  wire          hi_write,
    input  wire          lo_write,
    input  wire data_t   hilo_write_data,
    output logic         busy,
    output hilo_t        hilo
);

    // number of busy cycles for one operation
    localparam int STEPS = DATA_W / STEP_BITS;
    localparam int CNT_W = $clog2(STEPS);

    // the step count has to divide the word evenly
    if ((STEP_BITS != 1) && (STEP_BITS != 2) && (STEP_BITS != 4))
    begin : g_bad_step
        $error("muldiv_unit: STEP_BITS must be 1, 2 or 4");
    end

    // control state of the running operation
    logic [CNT_W-1:0]    cnt;
    logic                op_div;
    logic                neg_res;
    logic                neg_rem;

    // work register
    // multiply keeps the partial product on top and the multiplier below
    // divide keeps the partial remainder on top and dividend/quotient below
    logic [2*DATA_W-1:0] work;

    // multiplicand for multiply, divisor for divide
    data_t               operand;

    logic                start_div;
    logic                neg_a;
    logic                neg_b;
    data_t               abs_a;
    data_t               abs_b;
    logic [2*DATA_W-1:0] step_work;
    logic [2*DATA_W-1:0] fixed;

    assign start_div = (md_req.func == FUNC_DIV);

    // signed requests run on magnitudes, the signs are remembered for the end
    assign neg_a = md_req.sign && source_a[DATA_W-1];
    assign neg_b = md_req.sign && source_b[DATA_W-1];
    assign abs_a = neg_a ? -source_a : source_a;
    assign abs_b = neg_b ? -source_b : source_b;

    // STEP_BITS iterations of shift-and-add or restoring division per clock
    always_comb
    begin
        logic [DATA_W:0] sum;
        logic [DATA_W:0] trial;
        step_work = work;
        for (int k = 0; k < STEP_BITS; k++)
        begin
            // add the multiplicand when the current multiplier bit is set
            sum = {1'b0, step_work[2*DATA_W-1:DATA_W]} +
                  (step_work[0] ? {1'b0, operand} : {(DATA_W+1){1'b0}});
            // partial remainder shifted left with the next dividend bit
            trial = {step_work[2*DATA_W-1:DATA_W], step_work[DATA_W-1]};
            if (op_div)
            begin
                if (trial >= {1'b0, operand})
                begin
                    trial     = trial - {1'b0, operand};
                    step_work = {trial[DATA_W-1:0], step_work[DATA_W-2:0], 1'b1};
                end
                else
                begin
                    step_work = {trial[DATA_W-1:0], step_work[DATA_W-2:0], 1'b0};
                end
            end
            else
            begin
                // the carry of the add shifts down together with the product
                step_work = {sum, step_work[DATA_W-1:1]};
            end
        end
    end

    // sign fix applied on the last step
    // product and quotient are negated when the operand signs differ
    // the remainder follows the sign of the dividend
    always_comb
    begin
        fixed = step_work;
        if (op_div)
        begin
            if (neg_res)
            begin
                fixed[DATA_W-1:0] = -step_work[DATA_W-1:0];
            end
            if (neg_rem)
            begin
                fixed[2*DATA_W-1:DATA_W] = -step_work[2*DATA_W-1:DATA_W];
            end
        end
        else if (neg_res)
        begin
            fixed = -step_work;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy    <= 1'b0;
            cnt     <= '0;
            op_div  <= 1'b0;
            neg_res <= 1'b0;
            neg_rem <= 1'b0;
            hilo    <= '0;
        end
        else
        begin
            if (start)
            begin
                busy    <= 1'b1;
                cnt     <= CNT_W'(STEPS - 1);
                op_div  <= start_div;
                neg_res <= neg_a ^ neg_b;
                neg_rem <= start_div && neg_a;
            end
            else if (busy)
            begin
                // the final step writes HI/LO on the same edge that drops busy
                if (cnt == '0)
                begin
                    busy <= 1'b0;
                    hilo <= fixed;
                end
                else
                begin
                    cnt <= cnt - 1'b1;
                end
            end
            // MTHI and MTLO land directly
            if (hi_write)
            begin
                hilo.hi <= hilo_write_data;
            end
            if (lo_write)
            begin
                hilo.lo <= hilo_write_data;
            end
        end
    end

    // operands are loaded at start and then iterate while busy
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            operand <= start_div ? abs_b : abs_a;
            work    <= {{DATA_W{1'b0}}, start_div ? abs_a : abs_b};
        end
        else if (busy)
        begin
            work <= step_work;
        end
    end

    // the stage holds HI/LO instructions back while an operation runs
    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!arst_n)
        start |-> !busy
    ) else $error("muldiv_unit: start while busy");

    a_no_write_busy : assert property (
        @(posedge clk) disable iff (!arst_n)
        (hi_write || lo_write) |-> !busy
    ) else $error("muldiv_unit: HI/LO write while busy");

endmodule

`default_nettype wire

/* hdl/sglalu.sv */
`timescale 1ns/1ps
`default_nettype none

module sglalu
    import mips_ex_pkg::*;
(
    input  wire ex_req_t req,
    input  wire hilo_t   hilo,
    output data_t        result,
    output logic         ov,
    output data_t        cp0_rd_data,
    output md_req_t      md_req,
    output logic         hi_write,
    output logic         lo_write,
    output data_t        hilo_write_data
);

    // short names for the two operands
    data_t      a;
    data_t      b;

    // shift amount comes from the low five bits of the second operand
    logic [4:0] shamt;

    data_t      add_result;
    data_t      sub_result;
    logic       slt_signed;
    logic       slt_unsigned;

    // result of the AND function once the move opers are taken into account
    data_t      move_result;

    logic       is_muldiv;

    assign a     = req.source_a;
    assign b     = req.source_b;
    assign shamt = b[4:0];

    assign add_result = a + b;
    assign sub_result = a - b;

    // the same compare in both flavours and the oper picks one later
    assign slt_signed   = $signed(a) < $signed(b);
    assign slt_unsigned = a < b;

    // CP0 write data is the rt operand and passes through untouched
    assign cp0_rd_data = b;

    // MTHI and MTLO both write the rs operand
    assign hi_write        = (req.oper == OPER_MTHI);
    assign lo_write        = (req.oper == OPER_MTLO);
    assign hilo_write_data = a;

    // only multiply and divide are handed to the iterative unit
    // every other function reads as FUNC_NONE there so the stage can test for zero
    assign is_muldiv   = (req.func == FUNC_MUL) || (req.func == FUNC_DIV);
    assign md_req.func = is_muldiv ? req.func : FUNC_NONE;
    assign md_req.sign = (req.oper != OPER_ALUU);

    // the move opers share the AND function code
    always_comb
    begin
        case (req.oper)
            OPER_MFHI: move_result = hilo.hi;
            OPER_MFLO: move_result = hilo.lo;
            OPER_MFC0: move_result = req.cp0_rt_data;
            default:   move_result = a & b;
        endcase
    end

    always_comb
    begin
        case (req.func)
            FUNC_AND:
                result = move_result;
            FUNC_OR:
                result = a | b;
            FUNC_XOR:
                result = a ^ b;
            FUNC_NOR:
                result = ~(a | b);
            // immediate sits in the low half of b and moves to the top
            FUNC_LUI:
                result = {b[DATA_W/2-1:0], {(DATA_W/2){1'b0}}};
            FUNC_SLL:
                result = a << shamt;
            FUNC_SRL:
                result = a >> shamt;
            // arithmetic shift replicates the sign bit of a into the vacated bits
            FUNC_SRA:
                result = data_t'($signed(a) >>> shamt);
            FUNC_ADD:
                result = add_result;
            FUNC_SUB:
                result = sub_result;
            // signed compare only under the signed class and unsigned for everything else
            FUNC_SLT:
                result = {{(DATA_W-1){1'b0}},
                          (req.oper == OPER_ALUS) ? slt_signed : slt_unsigned};
            // multiply, divide and none give nothing here
            default:
                result = '0;
        endcase
    end

    // two's complement overflow is reported only for the signed class
    // add overflows when both signs agree and the sum sign differs
    // subtract overflows when the signs differ and the difference takes the sign of b
    always_comb
    begin
        ov = 1'b0;
        if (req.oper == OPER_ALUS)
        begin
            if (req.func == FUNC_ADD)
            begin
                ov = (a[DATA_W-1] == b[DATA_W-1]) &&
                     (add_result[DATA_W-1] != a[DATA_W-1]);
            end
            else if (req.func == FUNC_SUB)
            begin
                ov = (a[DATA_W-1] != b[DATA_W-1]) &&
                     (sub_result[DATA_W-1] != a[DATA_W-1]);
            end
        end
    end

endmodule

`default_nettype wire
